//--- spi_cmd_top.f
+incdir+source
source/spi_cmd_pkg.sv
source/wb_bus_pkg.sv
source/spi_byte_link.sv
source/spi_cmd_parser.sv
source/ctrl_regs.sv
source/word_ram.sv
source/spi_cmd_top.sv
dv/tb_clock_gen.sv
dv/spi_cmd_properties.sv
dv/spi_cmd_tb.sv

//--- Makefile
TOP := spi_cmd_tb

all: run

build:
	verilator --binary --timing --assert -f spi_cmd_top.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall -f spi_cmd_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- dv/spi_cmd_tb.sv
`timescale 1ns/100ps
`include "spi_cmd_cfg.svh"

module spi_cmd_tb;
    localparam int        HALF_CLKS  = 8;
    localparam int        GAP_CLKS   = 8;
    localparam int        DRIVE_NS   = 10;
    localparam int        CLK_NS     = 100;
    localparam bit [31:0] SEED       = 32'h764e5e7e;
    localparam int        MAX_FRAMES = 32;
    localparam int        MAX_BYTES  = 44;
    localparam int        BYTE_CLKS  = 2 * HALF_CLKS * `SPI_BYTE_W + GAP_CLKS;
    // twice the worst case, every frame at full length
    localparam longint    WATCHDOG_NS =
        longint'(MAX_FRAMES) * (MAX_BYTES * BYTE_CLKS + 2 * GAP_CLKS) * CLK_NS * 2;

    logic        clk;
    logic        rst_n;
    logic        spi_scl;
    logic        spi_sdi;
    logic        spi_sel;
    logic        spi_sdo;
    logic [15:0] sum;
    logic [15:0] num1;
    logic [15:0] num2;
    logic [15:0] num3;
    logic        en;

    logic [15:0] ref_regs [5];
    logic [15:0] ref_ram [`SPI_RAM_DEPTH];
    logic [7:0]  frame_tx [$];
    logic [7:0]  frame_rx [$];
    logic [7:0]  exp_q [$];
    logic [7:0]  got_q [$];

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(5)) clk_gen_i (.clk, .rst_n);

    spi_cmd_top dut_i (
        .clk, .rst_n, .spi_scl, .spi_sdi, .spi_sel, .spi_sdo,
        .sum, .num1, .num2, .num3, .en
    );

    bind spi_cmd_parser spi_cmd_properties props_i (
        .clk, .rst_n, .wb_cyc, .wb_we, .wb_adr, .reg_stb, .reg_ack, .ram_stb, .ram_ack
    );

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_equal(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_NS;
    endtask

    // mode 1: change data on the rising edge, sample on the falling edge
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_sdi = tx[i];
            spi_scl = 1'b1;
            wait_cycles(HALF_CLKS);
            rx[i]   = spi_sdo;
            spi_scl = 1'b0;
            wait_cycles(HALF_CLKS);
        end
        wait_cycles(GAP_CLKS);
    endtask

    task automatic run_frame();
        logic [7:0] rx;
        frame_rx.delete();
        spi_sel = 1'b0;
        wait_cycles(GAP_CLKS);
        foreach (frame_tx[i]) begin
            shift_byte(frame_tx[i], rx);
            frame_rx.push_back(rx);
        end
        spi_sel = 1'b1;
        wait_cycles(GAP_CLKS);
        frame_tx.delete();
    endtask

    function automatic logic [15:0] expected_word(input bit from_ram, input logic [7:0] addr);
        if (from_ram) begin
            if (addr < `SPI_RAM_DEPTH) begin
                return ref_ram[int'(addr)];
            end
            return 16'h0;
        end
        if (addr == 8'd0) begin
            return sum;
        end else if (addr <= 8'd4) begin
            return ref_regs[int'(addr)];
        end
        return 16'h0;
    endfunction

    task automatic set_enable(input bit value);
        frame_tx.push_back({7'h0, value});
        run_frame();
        ref_regs[4] = {15'h0, value};
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
        frame_tx = '{8'h02, addr, data[15:8], data[7:0]};
        run_frame();
        if (addr == 8'd4) begin
            ref_regs[4] = {15'h0, data[0]};
        end else if (addr >= 8'd1 && addr <= 8'd3) begin
            ref_regs[int'(addr)] = data;
        end
    endtask

    task automatic read_reg(input logic [7:0] addr);
        logic [15:0] exp;
        exp = expected_word(1'b0, addr);
        exp_q.push_back(exp[15:8]);
        exp_q.push_back(exp[7:0]);
        frame_tx = '{8'h03, addr, 8'h00, 8'h00};
        run_frame();
        got_q.push_back(frame_rx[2]);
        got_q.push_back(frame_rx[3]);
    endtask

    task automatic write_ram(input logic [7:0] start, input int count);
        logic [15:0] word;
        logic [7:0]  addr;
        frame_tx = '{8'h06, start, 8'(count >> 8), 8'(count)};
        for (int i = 0; i < count; i++) begin
            word = 16'($urandom);
            addr = start + 8'(i);
            frame_tx.push_back(word[15:8]);
            frame_tx.push_back(word[7:0]);
            if (addr < `SPI_RAM_DEPTH) begin
                ref_ram[int'(addr)] = word;
            end
        end
        run_frame();
    endtask

    task automatic read_ram(input logic [7:0] start, input int count);
        logic [15:0] word;
        frame_tx = '{8'h07, start, 8'(count >> 8), 8'(count)};
        for (int i = 0; i < count; i++) begin
            word = expected_word(1'b1, start + 8'(i));
            exp_q.push_back(word[15:8]);
            exp_q.push_back(word[7:0]);
            frame_tx.push_back(8'h00);
            frame_tx.push_back(8'h00);
        end
        run_frame();
        for (int i = 4; i < frame_rx.size(); i++) begin
            got_q.push_back(frame_rx[i]);
        end
    endtask

    task automatic check_outputs();
        check_equal("num1", num1, ref_regs[1]);
        check_equal("num2", num2, ref_regs[2]);
        check_equal("num3", num3, ref_regs[3]);
        check_equal("en", {15'h0, en}, ref_regs[4]);
    endtask

    // returned bytes against the model, in order
    initial begin
        forever begin
            @(posedge clk);
            while (got_q.size() > 0) begin
                if (exp_q.size() == 0) begin
                    $display("a returned byte arrived with no expected value");
                    stop_run();
                end else begin
                    check_equal("read byte", {8'h0, got_q.pop_front()},
                                {8'h0, exp_q.pop_front()});
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        stop_run();
    end

    initial begin
        logic [7:0] start;
        int         count;
        void'($urandom(SEED));
        spi_scl = 1'b0;
        spi_sdi = 1'b0;
        spi_sel = 1'b1;
        sum     = 16'($urandom);
        foreach (ref_regs[i]) ref_regs[i] = '0;
        foreach (ref_ram[i]) ref_ram[i] = '0;
        @(posedge rst_n);
        wait_cycles(4);
        check_outputs();

        set_enable(1'b1);
        check_outputs();
        read_reg(8'd4);
        set_enable(1'b0);
        check_outputs();
        read_reg(8'd4);
        set_enable(1'b1);
        check_outputs();

        for (int r = 1; r <= 3; r++) begin
            write_reg(8'(r), 16'($urandom));
            check_outputs();
            read_reg(8'(r));
        end
        read_reg(8'd0);
        // unmapped address
        write_reg(8'd9, 16'($urandom));
        check_outputs();
        read_reg(8'd9);

        start = 8'($urandom_range(4, 40));
        count = $urandom_range(10, 20);
        write_ram(start, count);
        read_ram(start, count);

        // words past the end wrap onto 0..3 in the index, must not land there
        write_ram(8'd0, 4);
        write_ram(8'(`SPI_RAM_DEPTH - 4), 8);
        read_ram(8'(`SPI_RAM_DEPTH - 4), 8);
        read_ram(8'd0, 4);

        // a decoded 0x00 here would clear en
        frame_tx = '{8'h5a, 8'h00, 8'h02, 8'h03};
        run_frame();
        check_outputs();
        // cut before the first word is complete
        frame_tx = '{8'h06, start, 8'h00, 8'h04, 8'hc3};
        run_frame();
        check_outputs();
        read_ram(start, count);
        read_reg(8'd1);

        wait_cycles(GAP_CLKS);
        if (got_q.size() != 0 || exp_q.size() != 0) begin
            $display("read data was left unchecked at the end of the run");
            stop_run();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- dv/spi_cmd_properties.sv
`timescale 1ns/100ps

module spi_cmd_properties
    import wb_bus_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     wb_cyc,
    input logic     wb_we,
    input wb_addr_t wb_adr,
    input logic     reg_stb,
    input logic     reg_ack,
    input logic     ram_stb,
    input logic     ram_ack
);
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_stb || ram_stb) |-> wb_cyc)
        else $error("strobe raised without wb_cyc");

    // request must not move until the slave answers
    a_reg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_stb && !reg_ack) |=> (reg_stb && $stable(wb_adr) && $stable(wb_we)))
        else $error("register strobe dropped or changed before ack");

    a_ram_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ram_stb && !ram_ack) |=> (ram_stb && $stable(wb_adr) && $stable(wb_we)))
        else $error("RAM strobe dropped or changed before ack");

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_stb && ram_stb))
        else $error("both slave strobes high together");

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release a little after the edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

//--- source/spi_cmd_top.sv
`timescale 1ns/100ps

module spi_cmd_top
    import spi_cmd_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     spi_scl,
    input  logic     spi_sdi,
    input  logic     spi_sel,
    output logic     spi_sdo,
    input  wb_data_t sum,
    output wb_data_t num1,
    output wb_data_t num2,
    output wb_data_t num3,
    output logic     en
);
    spi_byte_t rx_byte;
    spi_byte_t tx_byte;
    logic      byte_start;
    logic      byte_done;
    logic      frame_active;
    logic      wb_cyc;
    logic      wb_we;
    wb_addr_t  wb_adr;
    wb_data_t  wb_dat_w;
    logic      reg_stb;
    logic      reg_ack;
    wb_data_t  reg_dat_r;
    logic      ram_stb;
    logic      ram_ack;
    wb_data_t  ram_dat_r;

    spi_byte_link link_i (
        .clk, .rst_n, .spi_scl, .spi_sdi, .spi_sel, .tx_byte,
        .spi_sdo, .rx_byte, .byte_start, .byte_done, .frame_active
    );

    spi_cmd_parser parser_i (
        .clk, .rst_n, .rx_byte, .byte_start, .byte_done, .frame_active,
        .reg_ack, .reg_dat_r, .ram_ack, .ram_dat_r, .tx_byte,
        .wb_cyc, .wb_we, .wb_adr, .wb_dat_w, .reg_stb, .ram_stb
    );

    ctrl_regs regs_i (
        .clk, .rst_n, .wb_cyc, .wb_stb(reg_stb), .wb_we, .wb_adr, .wb_dat_w,
        .sum, .wb_ack(reg_ack), .wb_dat_r(reg_dat_r), .num1, .num2, .num3, .en
    );

    word_ram ram_i (
        .clk, .rst_n, .wb_cyc, .wb_stb(ram_stb), .wb_we, .wb_adr, .wb_dat_w,
        .wb_ack(ram_ack), .wb_dat_r(ram_dat_r)
    );

endmodule

//--- source/word_ram.sv
`timescale 1ns/100ps
`include "spi_cmd_cfg.svh"

module word_ram
    import wb_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output logic     wb_ack,
    output wb_data_t wb_dat_r
);
    localparam int AW = $clog2(`SPI_RAM_DEPTH);

    wb_data_t      mem [`SPI_RAM_DEPTH];
    logic          access;
    logic          in_range;
    logic [AW-1:0] idx;

    assign access = wb_cyc & wb_stb & ~wb_ack;
    assign in_range = (int'(wb_adr) < `SPI_RAM_DEPTH);
    assign idx = wb_adr[AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // past the end, writes drop and reads return zero
    always_ff @(posedge clk) begin
        if (access && wb_we && in_range) begin
            mem[idx] <= wb_dat_w;
        end
        if (access && !wb_we) begin
            wb_dat_r <= in_range ? mem[idx] : '0;
        end
    end

endmodule

//--- source/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs
    import spi_cmd_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    input  wb_data_t sum,
    output logic     wb_ack,
    output wb_data_t wb_dat_r,
    output wb_data_t num1,
    output wb_data_t num2,
    output wb_data_t num3,
    output logic     en
);
    logic     access;
    wb_data_t rd_mux;

    // one access per strobe, ack drops it
    assign access = wb_cyc & wb_stb & ~wb_ack;

    always_comb begin
        case (wb_adr)
            REG_SUM:  rd_mux = sum;
            REG_NUM1: rd_mux = num1;
            REG_NUM2: rd_mux = num2;
            REG_NUM3: rd_mux = num3;
            REG_EN:   rd_mux = wb_data_t'(en);
            default:  rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            num1   <= '0;
            num2   <= '0;
            num3   <= '0;
            en     <= 1'b0;
        end else begin
            wb_ack <= access;
            if (access && wb_we) begin
                case (wb_adr)
                    REG_NUM1: num1 <= wb_dat_w;
                    REG_NUM2: num2 <= wb_dat_w;
                    REG_NUM3: num3 <= wb_dat_w;
                    REG_EN:   en <= wb_dat_w[0];
                    default:  ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

//--- source/spi_cmd_parser.sv
`timescale 1ns/100ps
`include "spi_cmd_cfg.svh"

module spi_cmd_parser
    import spi_cmd_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  spi_byte_t rx_byte,
    input  logic      byte_start,
    input  logic      byte_done,
    input  logic      frame_active,
    input  logic      reg_ack,
    input  wb_data_t  reg_dat_r,
    input  logic      ram_ack,
    input  wb_data_t  ram_dat_r,
    output spi_byte_t tx_byte,
    output logic      wb_cyc,
    output logic      wb_we,
    output wb_addr_t  wb_adr,
    output wb_data_t  wb_dat_w,
    output logic      reg_stb,
    output logic      ram_stb
);
    parse_state_e state, state_nxt;
    opcode_e      op;
    logic [`SPI_WORD_W-1:0] cnt, cnt_nxt;
    wb_addr_t     addr, addr_nxt;
    spi_byte_t    data_hi;
    wb_data_t     rd_word;
    logic         issue;
    logic         issue_ram;
    logic         issue_we;
    wb_addr_t     issue_adr;
    wb_data_t     issue_dat;
    logic         bus_ack;
    wb_data_t     bus_dat_r;

    assign bus_ack = (reg_stb & reg_ack) | (ram_stb & ram_ack);
    assign bus_dat_r = reg_stb ? reg_dat_r : ram_dat_r;

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        addr_nxt  = addr;
        issue     = 1'b0;
        issue_ram = 1'b0;
        issue_we  = 1'b0;
        issue_adr = addr;
        issue_dat = {data_hi, rx_byte};
        if (!frame_active) begin
            state_nxt = S_IDLE;
        end else if (byte_done) begin
            case (state)
                S_IDLE: begin
                    case (rx_byte)
                        OP_DISABLE, OP_ENABLE: begin
                            // bit 0 of the opcode is the new enable value
                            issue     = 1'b1;
                            issue_we  = 1'b1;
                            issue_adr = wb_addr_t'(REG_EN);
                            issue_dat = wb_data_t'(rx_byte[0]);
                        end
                        OP_WR_REG, OP_RD_REG: state_nxt = S_REG_ADDR;
                        OP_WR_RAM, OP_RD_RAM: state_nxt = S_RAM_ADDR;
                        default:              state_nxt = S_SKIP;
                    endcase
                end
                S_REG_ADDR: begin
                    addr_nxt = rx_byte;
                    if (op == OP_RD_REG) begin
                        issue     = 1'b1;
                        issue_adr = rx_byte;
                        state_nxt = S_RD_HI;
                    end else begin
                        state_nxt = S_WR_HI;
                    end
                end
                S_RAM_ADDR: begin
                    addr_nxt  = rx_byte;
                    state_nxt = S_CNT_HI;
                end
                S_CNT_HI: begin
                    cnt_nxt   = {rx_byte, cnt[`SPI_BYTE_W-1:0]};
                    state_nxt = S_CNT_LO;
                end
                S_CNT_LO: begin
                    cnt_nxt = {cnt[`SPI_WORD_W-1 -: `SPI_BYTE_W], rx_byte};
                    if (cnt_nxt == '0) begin
                        state_nxt = S_IDLE;
                    end else if (op == OP_RD_RAM) begin
                        // prefetch first word
                        issue     = 1'b1;
                        issue_ram = 1'b1;
                        state_nxt = S_RD_HI;
                    end else begin
                        state_nxt = S_WR_HI;
                    end
                end
                S_WR_HI: state_nxt = S_WR_LO;
                S_WR_LO: begin
                    issue    = 1'b1;
                    issue_we = 1'b1;
                    if (op == OP_WR_REG) begin
                        state_nxt = S_IDLE;
                    end else begin
                        issue_ram = 1'b1;
                        addr_nxt  = addr + 1'b1;
                        cnt_nxt   = cnt - 1'b1;
                        state_nxt = (cnt == 1) ? S_IDLE : S_WR_HI;
                    end
                end
                S_RD_HI: state_nxt = S_RD_LO;
                S_RD_LO: begin
                    if (op == OP_RD_REG || cnt == 1) begin
                        state_nxt = S_IDLE;
                    end else begin
                        addr_nxt  = addr + 1'b1;
                        cnt_nxt   = cnt - 1'b1;
                        issue     = 1'b1;
                        issue_ram = 1'b1;
                        issue_adr = addr_nxt;
                        state_nxt = S_RD_HI;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            op      <= OP_DISABLE;
            cnt     <= '0;
            addr    <= '0;
            wb_cyc  <= 1'b0;
            reg_stb <= 1'b0;
            ram_stb <= 1'b0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            addr  <= addr_nxt;
            if (frame_active && byte_done && state == S_IDLE) begin
                op <= opcode_e'(rx_byte);
            end
            if (bus_ack) begin
                wb_cyc  <= 1'b0;
                reg_stb <= 1'b0;
                ram_stb <= 1'b0;
            end else if (issue && !wb_cyc) begin
                wb_cyc  <= 1'b1;
                reg_stb <= ~issue_ram;
                ram_stb <= issue_ram;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue && !wb_cyc) begin
            wb_we    <= issue_we;
            wb_adr   <= issue_adr;
            wb_dat_w <= issue_dat;
        end
        if (bus_ack && !wb_we) begin
            rd_word <= bus_dat_r;
        end
        if (byte_done && state == S_WR_HI) begin
            data_hi <= rx_byte;
        end
    end

    // high byte first, link samples this during byte_start
    always_comb begin
        tx_byte = '0;
        if (byte_start && state == S_RD_HI) begin
            tx_byte = rd_word[`SPI_WORD_W-1 -: `SPI_BYTE_W];
        end else if (byte_start && state == S_RD_LO) begin
            tx_byte = rd_word[`SPI_BYTE_W-1:0];
        end
    end

endmodule

//--- source/spi_byte_link.sv
`timescale 1ns/100ps
`include "spi_cmd_cfg.svh"

module spi_byte_link
    import spi_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      spi_scl,
    input  logic      spi_sdi,
    input  logic      spi_sel,
    input  spi_byte_t tx_byte,
    output logic      spi_sdo,
    output spi_byte_t rx_byte,
    output logic      byte_start,
    output logic      byte_done,
    output logic      frame_active
);
    localparam int SYN = `SPI_SYNC_STAGES;
    localparam int CNT_W = $clog2(`SPI_BYTE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SPI_BYTE_W - 1);

    logic [SYN-1:0]   scl_sync;
    logic [SYN-1:0]   sdi_sync;
    logic [SYN-1:0]   sel_sync;
    logic             scl_q;
    logic             scl_rise;
    logic             scl_fall;
    logic [CNT_W-1:0] bit_cnt;
    spi_byte_t        tx_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_sync <= '0;
            sdi_sync <= '0;
            sel_sync <= '1;
            scl_q    <= 1'b0;
        end else begin
            scl_sync <= {scl_sync[SYN-2:0], spi_scl};
            sdi_sync <= {sdi_sync[SYN-2:0], spi_sdi};
            sel_sync <= {sel_sync[SYN-2:0], spi_sel};
            scl_q    <= scl_sync[SYN-1];
        end
    end

    assign frame_active = ~sel_sync[SYN-1];
    assign scl_rise = frame_active & scl_sync[SYN-1] & ~scl_q;
    assign scl_fall = frame_active & ~scl_sync[SYN-1] & scl_q;
    assign spi_sdo = tx_sr[`SPI_BYTE_W-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            byte_start <= 1'b0;
            byte_done  <= 1'b0;
            tx_sr      <= '0;
        end else begin
            byte_start <= scl_rise && (bit_cnt == '0);
            byte_done  <= scl_fall && (bit_cnt == LAST_BIT);
            if (!frame_active || (scl_fall && bit_cnt == LAST_BIT)) begin
                bit_cnt <= '0;
            end else if (scl_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // first rising edge loads, later ones shift out the next bit
            if (!frame_active) begin
                tx_sr <= '0;
            end else if (byte_start) begin
                tx_sr <= tx_byte;
            end else if (scl_rise && bit_cnt != '0) begin
                tx_sr <= {tx_sr[`SPI_BYTE_W-2:0], 1'b0};
            end
        end
    end

    // msb first, complete when byte_done rises
    always_ff @(posedge clk) begin
        if (scl_fall) begin
            rx_byte <= {rx_byte[`SPI_BYTE_W-2:0], sdi_sync[SYN-1]};
        end
    end

endmodule

//--- source/wb_bus_pkg.sv
`include "spi_cmd_cfg.svh"

package wb_bus_pkg;

    // byte-wide address, covers registers and RAM
    typedef logic [7:0] wb_addr_t;

    typedef logic [`SPI_WORD_W-1:0] wb_data_t;

endpackage

//--- source/spi_cmd_pkg.sv
`include "spi_cmd_cfg.svh"

package spi_cmd_pkg;

    typedef logic [`SPI_BYTE_W-1:0] spi_byte_t;

    // first byte of every frame
    typedef enum logic [7:0] {
        OP_DISABLE = 8'h00,
        OP_ENABLE  = 8'h01,
        OP_WR_REG  = 8'h02,
        OP_RD_REG  = 8'h03,
        OP_WR_RAM  = 8'h06,
        OP_RD_RAM  = 8'h07
    } opcode_e;

    typedef enum logic [7:0] {
        REG_SUM  = 8'd0,
        REG_NUM1 = 8'd1,
        REG_NUM2 = 8'd2,
        REG_NUM3 = 8'd3,
        REG_EN   = 8'd4
    } reg_addr_e;

    typedef enum logic [3:0] {
        S_IDLE, S_REG_ADDR, S_RAM_ADDR, S_CNT_HI, S_CNT_LO,
        S_WR_HI, S_WR_LO, S_RD_HI, S_RD_LO, S_SKIP
    } parse_state_e;

endpackage

//--- source/spi_cmd_cfg.svh
`ifndef SPI_CMD_CFG_SVH
`define SPI_CMD_CFG_SVH

// serial byte and register word
`define SPI_BYTE_W      8
`define SPI_WORD_W      16

// internal RAM size in words
`define SPI_RAM_DEPTH   64

// flops per SPI pin before edge detection
`define SPI_SYNC_STAGES 2

`endif
